/* ebusSubsys.f */
ebusPkg.sv
feBridge.sv
ebusMux.sv
flagRegister.sv
edpSlice.sv
ebusSubsys.sv
tb_ebusSubsys.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_ebusSubsys
FILELIST ?= ebusSubsys.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)

/* tb_ebusSubsys.sv */
`timescale 1ns/1ps

module tb_ebusSubsys;

  localparam ebusPkg::tEbusData APR_INIT = 36'o123456701234;
  localparam ebusPkg::tEbusData PI_INIT = 36'o765432107654;
  localparam ebusPkg::tDiagFunc DS_UNMAPPED = 7'o077;
  localparam int TIMEOUT = 50;

  logic              clk;
  logic              rst;
  logic              cmdValid;
  logic              cmdReady;
  logic              cmdWrite;
  ebusPkg::tDiagFunc cmdFunc;
  ebusPkg::tEbusData cmdData;
  logic              rspValid;
  logic              rspReady;
  ebusPkg::tEbusData rspData;
  logic              arLoad;
  ebusPkg::tEbusData arIn;
  ebusPkg::tEbusData aprEvents;
  ebusPkg::tEbusData piEvents;

  integer            seed;
  int                errorCount;
  int                timeoutCount;
  // what the flag registers should hold, kept from the writes and events of the tests
  ebusPkg::tEbusData aprModel;
  ebusPkg::tEbusData piModel;

  ebusSubsys #(
    .APR_RESET (APR_INIT),
    .PI_RESET  (PI_INIT)
  ) i_ebusSubsys (
    .clk       (clk),
    .rst       (rst),
    .cmdValid  (cmdValid),
    .cmdReady  (cmdReady),
    .cmdWrite  (cmdWrite),
    .cmdFunc   (cmdFunc),
    .cmdData   (cmdData),
    .rspValid  (rspValid),
    .rspReady  (rspReady),
    .rspData   (rspData),
    .arLoad    (arLoad),
    .arIn      (arIn),
    .aprEvents (aprEvents),
    .piEvents  (piEvents)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic checkWord(input string name, input ebusPkg::tEbusData expected,
                           input ebusPkg::tEbusData actual);
    if (actual !== expected)
    begin
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkReady(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("FAIL %s: expected %b, actual %b", name, expected, actual);
      errorCount++;
    end
  endtask

  function automatic ebusPkg::tEbusData randomWord();
    logic [63:0] raw;
    raw = {$random(seed), $random(seed)};
    return raw[35:0];
  endfunction

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic sendCommand(input logic write, input ebusPkg::tDiagFunc func,
                             input ebusPkg::tEbusData data);
    int waitCount;
    waitCount = 0;
    while (!cmdReady && waitCount < TIMEOUT)
    begin
      @(negedge clk);
      waitCount++;
    end
    if (!cmdReady)
    begin
      $display("ERROR: the bridge never raised cmdReady for function %o", func);
      timeoutCount++;
    end
    cmdValid = 1'b1;
    cmdWrite = write;
    cmdFunc = func;
    cmdData = data;
    @(negedge clk);
    cmdValid = 1'b0;
    cmdWrite = 1'b0;
    cmdData = '0;
  endtask

  task automatic waitResponse(output ebusPkg::tEbusData data);
    int waitCount;
    waitCount = 0;
    while (!rspValid && waitCount < TIMEOUT)
    begin
      @(negedge clk);
      waitCount++;
    end
    if (!rspValid)
    begin
      $display("ERROR: the bridge never raised rspValid for a read");
      timeoutCount++;
    end
    data = rspData;
  endtask

  task automatic diagWrite(input ebusPkg::tDiagFunc func, input ebusPkg::tEbusData data);
    sendCommand(1'b1, func, data);
  endtask

  task automatic diagRead(input ebusPkg::tDiagFunc func, output ebusPkg::tEbusData data);
    rspReady = 1'b1;
    sendCommand(1'b0, func, '0);
    waitResponse(data);
  endtask

  task automatic testReset();
    ebusPkg::tEbusData word;
    checkReady("reset cmdReady", 1'b1, cmdReady);
    checkReady("reset rspValid", 1'b0, rspValid);
    diagRead(ebusPkg::DS_APR_RD, word);
    checkWord("reset APR", APR_INIT, word);
    diagRead(ebusPkg::DS_PI_RD, word);
    checkWord("reset PI", PI_INIT, word);
  endtask

  task automatic testReadWrite();
    ebusPkg::tEbusData word;
    aprModel = randomWord();
    diagWrite(ebusPkg::DS_APR_WR, aprModel);
    diagRead(ebusPkg::DS_APR_RD, word);
    checkWord("write APR", aprModel, word);
    diagRead(ebusPkg::DS_PI_RD, word);
    checkWord("PI after APR write", piModel, word);
    piModel = randomWord();
    diagWrite(ebusPkg::DS_PI_WR, piModel);
    diagRead(ebusPkg::DS_PI_RD, word);
    checkWord("write PI", piModel, word);
    diagRead(ebusPkg::DS_APR_RD, word);
    checkWord("APR after PI write", aprModel, word);
  endtask

  task automatic testEvents();
    ebusPkg::tEbusData word;
    ebusPkg::tEbusData eventBits;
    eventBits = randomWord();
    aprEvents = eventBits;
    @(negedge clk);
    aprEvents = '0;
    aprModel = aprModel | eventBits;
    diagRead(ebusPkg::DS_APR_RD, word);
    checkWord("APR events", aprModel, word);
    aprModel = '0;
    diagWrite(ebusPkg::DS_APR_WR, aprModel);
    diagRead(ebusPkg::DS_APR_RD, word);
    checkWord("APR clear", aprModel, word);
  endtask

  task automatic testEdp();
    ebusPkg::tEbusData word;
    ebusPkg::tEbusData expected;
    expected = randomWord();
    diagWrite(ebusPkg::DS_EDP_WR, expected);
    diagRead(ebusPkg::DS_EDP_RD, word);
    checkWord("EDP diagnostic write", expected, word);
    expected = randomWord();
    arLoad = 1'b1;
    arIn = expected;
    @(negedge clk);
    arLoad = 1'b0;
    arIn = '0;
    diagRead(ebusPkg::DS_EDP_RD, word);
    checkWord("EDP arLoad", expected, word);
  endtask

  task automatic testUnmapped();
    ebusPkg::tEbusData word;
    diagRead(DS_UNMAPPED, word);
    checkWord("unmapped read", '0, word);
  endtask

  task automatic testBackPressure();
    ebusPkg::tEbusData held;
    // a nonzero word makes a held response distinguishable from the idle bus
    aprModel = randomWord();
    diagWrite(ebusPkg::DS_APR_WR, aprModel);
    rspReady = 1'b0;
    sendCommand(1'b0, ebusPkg::DS_APR_RD, '0);
    waitResponse(held);
    checkWord("stalled read data", aprModel, held);
    repeat (4)
    begin
      @(negedge clk);
      checkReady("stalled rspValid", 1'b1, rspValid);
      checkReady("stalled cmdReady", 1'b0, cmdReady);
      checkWord("stalled rspData", aprModel, rspData);
    end
    rspReady = 1'b1;
    @(negedge clk);
    checkReady("released rspValid", 1'b0, rspValid);
    checkReady("released cmdReady", 1'b1, cmdReady);
  endtask

  initial
  begin
    seed = 32966;
    errorCount = 0;
    timeoutCount = 0;
    aprModel = APR_INIT;
    piModel = PI_INIT;
    rst = 1'b1;
    cmdValid = 1'b0;
    cmdWrite = 1'b0;
    cmdFunc = '0;
    cmdData = '0;
    rspReady = 1'b1;
    arLoad = 1'b0;
    arIn = '0;
    aprEvents = '0;
    piEvents = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    testReset();
    testReadWrite();
    testEvents();
    testEdp();
    testUnmapped();
    testBackPressure();
    $display("errors: %0d wrong values, %0d timeouts", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* ebusSubsys.sv */
`timescale 1ns/1ps

module ebusSubsys #(
  parameter ebusPkg::tEbusData APR_RESET = '0,
  parameter ebusPkg::tEbusData PI_RESET = '0
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              cmdValid,
  output logic              cmdReady,
  input  logic              cmdWrite,
  input  ebusPkg::tDiagFunc cmdFunc,
  input  ebusPkg::tEbusData cmdData,
  output logic              rspValid,
  input  logic              rspReady,
  output ebusPkg::tEbusData rspData,
  input  logic              arLoad,
  input  ebusPkg::tEbusData arIn,
  input  ebusPkg::tEbusData aprEvents,
  input  ebusPkg::tEbusData piEvents
);

  ebusPkg::tDiagFunc  ds;
  logic               diagStrobe;
  ebusPkg::tEbusData  ebusData;

  // one driver pair per bus participant
  logic               feDriving;
  ebusPkg::tEbusData  feData;
  logic               aprDriving;
  ebusPkg::tEbusData  aprData;
  logic               piDriving;
  ebusPkg::tEbusData  piData;
  logic [0:ebusPkg::SLICE_COUNT-1] edpDriving;
  ebusPkg::tSliceData edpField [0:ebusPkg::SLICE_COUNT-1];

  feBridge feBridge (
    .clk        (clk),
    .rst        (rst),
    .cmdValid   (cmdValid),
    .cmdReady   (cmdReady),
    .cmdWrite   (cmdWrite),
    .cmdFunc    (cmdFunc),
    .cmdData    (cmdData),
    .rspValid   (rspValid),
    .rspReady   (rspReady),
    .rspData    (rspData),
    .ds         (ds),
    .diagStrobe (diagStrobe),
    .feDriving  (feDriving),
    .feData     (feData),
    .ebusData   (ebusData)
  );

  flagRegister #(
    .RD_FUNC     (ebusPkg::DS_APR_RD),
    .WR_FUNC     (ebusPkg::DS_APR_WR),
    .RESET_VALUE (APR_RESET)
  ) aprFlags (
    .clk        (clk),
    .rst        (rst),
    .ds         (ds),
    .diagStrobe (diagStrobe),
    .ebusData   (ebusData),
    .events     (aprEvents),
    .driving    (aprDriving),
    .data       (aprData)
  );

  flagRegister #(
    .RD_FUNC     (ebusPkg::DS_PI_RD),
    .WR_FUNC     (ebusPkg::DS_PI_WR),
    .RESET_VALUE (PI_RESET)
  ) piFlags (
    .clk        (clk),
    .rst        (rst),
    .ds         (ds),
    .diagStrobe (diagStrobe),
    .ebusData   (ebusData),
    .events     (piEvents),
    .driving    (piDriving),
    .data       (piData)
  );

  // slice 0 holds AR bits 0 to 5
  for (genvar i = 0; i < ebusPkg::SLICE_COUNT; i++)
  begin : edpSlices
    edpSlice #(
      .SLICE (i)
    ) slice (
      .clk        (clk),
      .rst        (rst),
      .ds         (ds),
      .diagStrobe (diagStrobe),
      .ebusData   (ebusData),
      .arLoad     (arLoad),
      .arIn       (arIn),
      .driving    (edpDriving[i]),
      .field      (edpField[i])
    );
  end

  ebusMux ebusMux (
    .feDriving  (feDriving),
    .feData     (feData),
    .aprDriving (aprDriving),
    .aprData    (aprData),
    .piDriving  (piDriving),
    .piData     (piData),
    .edpDriving (edpDriving),
    .edpField   (edpField),
    .ebusData   (ebusData)
  );

endmodule

/* edpSlice.sv */
`timescale 1ns/1ps

module edpSlice #(
  parameter int SLICE = 0
) (
  input  logic               clk,
  input  logic               rst,
  input  ebusPkg::tDiagFunc  ds,
  input  logic               diagStrobe,
  input  ebusPkg::tEbusData  ebusData,
  input  logic               arLoad,
  input  ebusPkg::tEbusData  arIn,
  output logic               driving,
  output ebusPkg::tSliceData field
);

  // first bit of this slice within the word
  localparam int BASE = SLICE * ebusPkg::SLICE_WIDTH;

  ebusPkg::tSliceData arField;
  logic               diagLoad;

  assign diagLoad = diagStrobe && (ds == ebusPkg::DS_EDP_WR);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      arField <= '0;
    end
    else if (diagLoad)
    begin
      arField <= ebusData[BASE +: ebusPkg::SLICE_WIDTH];
    end
    else if (arLoad)
    begin
      arField <= arIn[BASE +: ebusPkg::SLICE_WIDTH];
    end
  end

  // the multiplexer reassembles the word from all six slices
  assign driving = (ds == ebusPkg::DS_EDP_RD);
  assign field = arField;

endmodule

/* flagRegister.sv */
`timescale 1ns/1ps

module flagRegister #(
  parameter ebusPkg::tDiagFunc RD_FUNC = ebusPkg::DS_APR_RD,
  parameter ebusPkg::tDiagFunc WR_FUNC = ebusPkg::DS_APR_WR,
  parameter ebusPkg::tEbusData RESET_VALUE = '0
) (
  input  logic              clk,
  input  logic              rst,
  input  ebusPkg::tDiagFunc ds,
  input  logic              diagStrobe,
  input  ebusPkg::tEbusData ebusData,
  input  ebusPkg::tEbusData events,
  output logic              driving,
  output ebusPkg::tEbusData data
);

  ebusPkg::tEbusData flags;
  logic              diagLoad;

  assign diagLoad = diagStrobe && (ds == WR_FUNC);

  // flags are sticky until software overwrites the whole register
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      flags <= RESET_VALUE;
    end
    else if (diagLoad)
    begin
      // an event in the same cycle as the load is lost
      flags <= ebusData;
    end
    else
    begin
      flags <= flags | events;
    end
  end

  assign driving = (ds == RD_FUNC);
  assign data = flags;

endmodule

/* ebusMux.sv */
`timescale 1ns/1ps

module ebusMux (
  input  logic               feDriving,
  input  ebusPkg::tEbusData  feData,
  input  logic               aprDriving,
  input  ebusPkg::tEbusData  aprData,
  input  logic               piDriving,
  input  ebusPkg::tEbusData  piData,
  input  logic [0:ebusPkg::SLICE_COUNT-1] edpDriving,
  input  ebusPkg::tSliceData edpField [0:ebusPkg::SLICE_COUNT-1],
  output ebusPkg::tEbusData  ebusData
);

  ebusPkg::tEbusData edpWord;

  // slice i owns bits 6i through 6i+5, so slice 0 carries the top of the word
  always_comb
  begin
    edpWord = '0;
    for (int i = 0; i < ebusPkg::SLICE_COUNT; i++)
    begin
      edpWord[i*ebusPkg::SLICE_WIDTH +: ebusPkg::SLICE_WIDTH] = edpField[i];
    end
  end

  // fixed priority, the front end wins over every board
  always_comb
  begin
    if (feDriving)
    begin
      ebusData = feData;
    end
    else if (aprDriving)
    begin
      ebusData = aprData;
    end
    else if (piDriving)
    begin
      ebusData = piData;
    end
    else if (|edpDriving)
    begin
      // any one slice driving puts the whole EDP group on the bus
      ebusData = edpWord;
    end
    else
    begin
      ebusData = '0;
    end
  end

endmodule

/* feBridge.sv */
`timescale 1ns/1ps

module feBridge (
  input  logic              clk,
  input  logic              rst,
  input  logic              cmdValid,
  output logic              cmdReady,
  input  logic              cmdWrite,
  input  ebusPkg::tDiagFunc cmdFunc,
  input  ebusPkg::tEbusData cmdData,
  output logic              rspValid,
  input  logic              rspReady,
  output ebusPkg::tEbusData rspData,
  output ebusPkg::tDiagFunc ds,
  output logic              diagStrobe,
  output logic              feDriving,
  output ebusPkg::tEbusData feData,
  input  ebusPkg::tEbusData ebusData
);

  // no board decodes this code, so the bus stays quiet between cycles
  localparam ebusPkg::tDiagFunc DS_IDLE = 7'o177;

  ebusPkg::tFeState  state;
  logic              writeReg;
  ebusPkg::tDiagFunc funcReg;
  ebusPkg::tEbusData dataReg;
  logic              cmdAccept;
  logic              inCycle;

  assign cmdAccept = cmdValid && cmdReady;
  assign inCycle = (state == ebusPkg::CYCLE);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= ebusPkg::IDLE;
      writeReg <= 1'b0;
    end
    else
    begin
      case (state)
        ebusPkg::IDLE:
        begin
          if (cmdAccept)
          begin
            state <= ebusPkg::CYCLE;
            writeReg <= cmdWrite;
          end
        end
        ebusPkg::CYCLE:
        begin
          // writes have nothing to return, reads wait for the consumer
          if (writeReg)
            state <= ebusPkg::IDLE;
          else
            state <= ebusPkg::RESP;
        end
        ebusPkg::RESP:
        begin
          if (rspReady)
            state <= ebusPkg::IDLE;
        end
        default:
        begin
          state <= ebusPkg::IDLE;
        end
      endcase
    end
  end

  // the command is held here so the outside port is free after acceptance
  always_ff @(posedge clk)
  begin
    if (cmdAccept)
    begin
      funcReg <= cmdFunc;
      dataReg <= cmdData;
    end
  end

  // read data is sampled at the end of the bus cycle
  always_ff @(posedge clk)
  begin
    if (inCycle && !writeReg)
      rspData <= ebusData;
  end

  assign cmdReady = (state == ebusPkg::IDLE);
  assign rspValid = (state == ebusPkg::RESP);

  assign ds = inCycle ? funcReg : DS_IDLE;
  assign diagStrobe = inCycle && writeReg;
  assign feDriving = inCycle && writeReg;
  assign feData = dataReg;

endmodule

/* ebusPkg.sv */
package ebusPkg;

  // widths of the diagnostic side of the EBUS
  localparam int EBUS_WIDTH = 36;
  localparam int FUNC_WIDTH = 7;
  localparam int SLICE_WIDTH = 6;

  // the EDP data path is built from this many slices across one word
  localparam int SLICE_COUNT = EBUS_WIDTH / SLICE_WIDTH;

  // bit 0 is the most significant bit, as on the backplane
  typedef logic [0:EBUS_WIDTH-1] tEbusData;

  // diagnostic function select, carried on ds
  typedef logic [0:FUNC_WIDTH-1] tDiagFunc;

  // one EDP slice field, in the same bit order as the word
  typedef logic [0:SLICE_WIDTH-1] tSliceData;

  // diagnostic function codes
  // read codes make a board drive the bus, write codes load it on diagStrobe
  localparam tDiagFunc DS_APR_RD = 7'o00;
  localparam tDiagFunc DS_APR_WR = 7'o01;
  localparam tDiagFunc DS_PI_RD  = 7'o02;
  localparam tDiagFunc DS_PI_WR  = 7'o03;
  localparam tDiagFunc DS_EDP_RD = 7'o04;
  localparam tDiagFunc DS_EDP_WR = 7'o05;

  // front end sequencing, one diagnostic bus cycle per command
  typedef enum logic [1:0] {
    IDLE,
    CYCLE,
    RESP
  } tFeState;

endpackage
